//--- Bender.yml
package:
  name: conv_post

sources:
  - files:
      - hdl/pe_pkg.sv
      - hdl/tile_ctrl.sv
      - hdl/mac_array.sv
      - hdl/post_pipe.sv
      - hdl/param_ram.sv
      - hdl/param_arbiter.sv
      - hdl/axil_param_port.sv
      - hdl/conv_post_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/conv_post_assertions.sv
      - testbench/conv_post_tb.sv

//--- hdl/axil_param_port.sv
module axil_param_port (
  input  logic             clk,
  input  logic             reset,
  input  logic [7:0]       awaddr,
  input  logic             awvalid,
  output logic             awready,
  input  logic [31:0]      wdata,
  input  logic [3:0]       wstrb,
  input  logic             wvalid,
  output logic             wready,
  output logic [1:0]       bresp,
  output logic             bvalid,
  input  logic             bready,
  input  logic [7:0]       araddr,
  input  logic             arvalid,
  output logic             arready,
  output logic [31:0]      rdata,
  output logic [1:0]       rresp,
  output logic             rvalid,
  input  logic             rready,
  output pe_pkg::mem_req_t req,
  output logic             req_valid,
  input  logic             req_ready,
  input  pe_pkg::param_t   mem_rdata,
  input  logic             mem_rvalid
);

  typedef enum logic [2:0] {S_IDLE, S_WREQ, S_BRESP, S_RREQ, S_RWAIT, S_RRESP} state_t;

  state_t state;
  logic   wr_go;
  logic   rd_go;
  logic   rd_bias;  // read selects the bias field

  // write first when both arrive
  assign wr_go   = (state == S_IDLE) && awvalid && wvalid;
  assign rd_go   = (state == S_IDLE) && arvalid && !(awvalid && wvalid);
  assign awready = wr_go;
  assign wready  = wr_go;
  assign arready = rd_go;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:  if (wr_go) state <= S_WREQ;
                 else if (rd_go) state <= S_RREQ;
        S_WREQ:  if (req_ready) state <= S_BRESP;
        S_BRESP: if (bready) state <= S_IDLE;
        S_RREQ:  if (req_ready) state <= S_RWAIT;
        S_RWAIT: if (mem_rvalid) state <= S_RRESP;
        S_RRESP: if (rready) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // addr[5:2] entry, addr[6] field
  always_ff @(posedge clk) begin
    if (wr_go) begin
      req.idx        <= awaddr[5:2];
      req.wr         <= 1'b1;
      req.we         <= (|wstrb) ? (awaddr[6] ? 2'b10 : 2'b01) : 2'b00;
      req.data.scale <= wdata[15:0];
      req.data.bias  <= wdata;
    end else if (rd_go) begin
      req.idx  <= araddr[5:2];
      req.wr   <= 1'b0;
      req.we   <= 2'b00;
      req.data <= '0;
      rd_bias  <= araddr[6];
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_RWAIT && mem_rvalid) begin
      rdata <= rd_bias ? mem_rdata.bias : {16'h0000, mem_rdata.scale};
    end
  end

  assign req_valid = (state == S_WREQ) || (state == S_RREQ);
  assign bvalid    = (state == S_BRESP);
  assign rvalid    = (state == S_RRESP);
  assign bresp     = pe_pkg::RESP_OKAY;
  assign rresp     = pe_pkg::RESP_OKAY;

endmodule

//--- hdl/conv_post_top.sv
module conv_post_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  pe_pkg::tile_cfg_t cfg,
  input  pe_pkg::in_beat_t  beat,
  output logic              out_valid,
  output pe_pkg::out_beat_t out,
  output logic              tile_done,
  output logic              busy,
  input  logic [7:0]        awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [31:0]       wdata,
  input  logic [3:0]        wstrb,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [7:0]        araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [31:0]       rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready
);

  logic             acc_clear;
  logic             acc_en;
  logic             row_issue;
  logic [3:0]       row_idx;
  logic             scale_on;
  pe_pkg::acc_t     row_val;
  logic             prd_en;
  logic [3:0]       prd_idx;
  pe_pkg::param_t   param_rdata;  // shared by pipeline and host
  pe_pkg::mem_req_t host_req;
  logic             host_valid;
  logic             host_ready;
  logic             host_rvalid;

  tile_ctrl u_tile_ctrl (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .cfg       (cfg),
    .busy      (busy),
    .acc_clear (acc_clear),
    .acc_en    (acc_en),
    .row_issue (row_issue),
    .row_idx   (row_idx),
    .scale_on  (scale_on),
    .tile_done (tile_done)
  );

  mac_array u_mac_array (
    .clk       (clk),
    .reset     (reset),
    .acc_clear (acc_clear),
    .acc_en    (acc_en),
    .beat      (beat),
    .row_sel   (row_idx),
    .row_val   (row_val)
  );

  post_pipe u_post_pipe (
    .clk       (clk),
    .reset     (reset),
    .row_issue (row_issue),
    .row_idx   (row_idx),
    .scale_on  (scale_on),
    .row_val   (row_val),
    .prd_en    (prd_en),
    .prd_idx   (prd_idx),
    .prd_data  (param_rdata),
    .out_valid (out_valid),
    .out       (out)
  );

  param_arbiter u_param_arbiter (
    .clk         (clk),
    .reset       (reset),
    .prd_en      (prd_en),
    .prd_idx     (prd_idx),
    .host_req    (host_req),
    .host_valid  (host_valid),
    .host_ready  (host_ready),
    .rdata       (param_rdata),
    .rdata_valid (host_rvalid)
  );

  axil_param_port u_axil_param_port (
    .clk        (clk),
    .reset      (reset),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .req        (host_req),
    .req_valid  (host_valid),
    .req_ready  (host_ready),
    .mem_rdata  (param_rdata),
    .mem_rvalid (host_rvalid)
  );

endmodule

//--- hdl/mac_array.sv
module mac_array (
  input  logic             clk,
  input  logic             reset,
  input  logic             acc_clear,
  input  logic             acc_en,
  input  pe_pkg::in_beat_t beat,
  input  logic [3:0]       row_sel,
  output pe_pkg::acc_t     row_val
);

  pe_pkg::acc_t acc [pe_pkg::ROW_NUM];
  pe_pkg::acc_t prod [pe_pkg::ROW_NUM];

  // activation times each row weight, sign extended to acc width
  always_comb begin
    for (int i = 0; i < pe_pkg::ROW_NUM; i++) begin
      prod[i] = pe_pkg::acc_t'($signed(beat.act) * $signed(beat.wts.w[i]));
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < pe_pkg::ROW_NUM; i++) begin
      if (reset) begin
        acc[i] <= '0;
      end else if (acc_clear) begin
        // first beat lands on a cleared row
        acc[i] <= acc_en ? prod[i] : '0;
      end else if (acc_en) begin
        acc[i] <= acc[i] + prod[i];
      end
    end
  end

  // one cycle from row select to row value
  always_ff @(posedge clk) begin
    row_val <= acc[row_sel];
  end

endmodule

//--- hdl/param_arbiter.sv
module param_arbiter (
  input  logic             clk,
  input  logic             reset,
  input  logic             prd_en,
  input  logic [3:0]       prd_idx,
  input  pe_pkg::mem_req_t host_req,
  input  logic             host_valid,
  output logic             host_ready,
  output pe_pkg::param_t   rdata,
  output logic             rdata_valid
);

  pe_pkg::mem_req_t pipe_req;
  pe_pkg::mem_req_t mem_req;
  logic             mem_en;

  assign pipe_req = '{idx: prd_idx, wr: 1'b0, we: 2'b00, data: '0};

  // pipeline has fixed priority, host only in idle slots
  assign host_ready = host_valid && !prd_en;
  assign mem_req    = prd_en ? pipe_req : host_req;
  assign mem_en     = prd_en || host_ready;

  // flag host read data, pipeline reads need no flag
  always_ff @(posedge clk) begin
    if (reset) rdata_valid <= 1'b0;
    else       rdata_valid <= host_ready && !host_req.wr;
  end

  param_ram u_param_ram (
    .clk    (clk),
    .req    (mem_req),
    .req_en (mem_en),
    .rdata  (rdata)
  );

endmodule

//--- hdl/param_ram.sv
module param_ram (
  input  logic             clk,
  input  pe_pkg::mem_req_t req,
  input  logic             req_en,
  output pe_pkg::param_t   rdata
);

  pe_pkg::param_t mem [pe_pkg::ROW_NUM];

  always_ff @(posedge clk) begin
    if (req_en && req.wr) begin
      if (req.we[pe_pkg::FLD_SCALE]) mem[req.idx].scale <= req.data.scale;
      if (req.we[pe_pkg::FLD_BIAS])  mem[req.idx].bias  <= req.data.bias;
    end
  end

  // synchronous read, data the cycle after the request
  always_ff @(posedge clk) begin
    if (req_en && !req.wr) rdata <= mem[req.idx];
  end

endmodule

//--- hdl/pe_pkg.sv
package pe_pkg;

  ////////////////////
  // core geometry and pipeline constants
  ////////////////////
  localparam int ROW_NUM     = 16;  // accumulator rows per core
  localparam int QUANT_SHIFT = 8;
  localparam int DRAIN_FIRST = 16;  // drain count of row 0
  localparam int DRAIN_LAST  = 32;  // drain count that ends the tile
  localparam int PIPE_DEPTH  = 3;   // issue to out
  localparam int SUM_W       = 50;  // acc x scale + bias, no overflow
  localparam int OUT_MAX     = 127;

  localparam int FLD_SCALE = 0;  // field enable bits of mem_req_t.we
  localparam int FLD_BIAS  = 1;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  ////////////////////
  // data types
  ////////////////////
  typedef logic signed [7:0] act_t;
  typedef logic signed [31:0] acc_t;

  typedef struct packed {
    act_t [ROW_NUM-1:0] w;  // one weight per row
  } w_vec_t;

  typedef struct packed {
    act_t   act;
    w_vec_t wts;
  } in_beat_t;

  typedef struct packed {
    logic [3:0]  mode;     // 1 scales, others bypass
    logic [31:0] nif_k_k;  // beats minus one
    logic [15:0] pof;      // total output channels
  } tile_cfg_t;

  typedef struct packed {
    logic [15:0]        scale;
    logic signed [31:0] bias;
  } param_t;

  typedef struct packed {
    logic [3:0] idx;
    logic       wr;
    logic [1:0] we;  // per field write enable
    param_t     data;
  } mem_req_t;

  typedef struct packed {
    logic [5:0] ch;   // output channel index
    logic [7:0] val;  // quantized value
  } out_beat_t;

endpackage

//--- hdl/post_pipe.sv
module post_pipe (
  input  logic              clk,
  input  logic              reset,
  input  logic              row_issue,
  input  logic [3:0]        row_idx,
  input  logic              scale_on,
  input  pe_pkg::acc_t      row_val,
  output logic              prd_en,
  output logic [3:0]        prd_idx,
  input  pe_pkg::param_t    prd_data,
  output logic              out_valid,
  output pe_pkg::out_beat_t out
);

  logic                             s1_valid;
  logic [3:0]                       s1_idx;
  logic                             s1_scale;
  logic signed [pe_pkg::SUM_W-1:0]  prod;
  logic signed [pe_pkg::SUM_W-1:0]  sum;

  logic                             s2_valid;
  logic [3:0]                       s2_idx;
  logic signed [pe_pkg::SUM_W-1:0]  s2_sum;
  logic signed [pe_pkg::SUM_W-1:0]  shifted;
  logic [7:0]                       sat_val;

  ////////////////////
  // stage 1, parameter read
  ////////////////////
  assign prd_en  = row_issue;
  assign prd_idx = row_idx;

  always_ff @(posedge clk) begin
    if (reset) s1_valid <= 1'b0;
    else       s1_valid <= row_issue;
    s1_idx   <= row_idx;
    s1_scale <= scale_on;
  end

  ////////////////////
  // stage 2, scale and bias
  ////////////////////
  assign prod = s1_scale ? row_val * $signed({1'b0, prd_data.scale})
                         : pe_pkg::SUM_W'(row_val);  // mode 0 bypass
  assign sum  = prod + $signed(prd_data.bias);

  always_ff @(posedge clk) begin
    if (reset) s2_valid <= 1'b0;
    else       s2_valid <= s1_valid;
    s2_idx <= s1_idx;
    s2_sum <= sum;
  end

  ////////////////////
  // stage 3, quantize and relu
  ////////////////////
  assign shifted = s2_sum >>> pe_pkg::QUANT_SHIFT;

  always_comb begin
    if (shifted < 0)                     sat_val = 8'd0;  // relu
    else if (shifted > pe_pkg::OUT_MAX)  sat_val = 8'(pe_pkg::OUT_MAX);
    else                                 sat_val = shifted[7:0];
  end

  always_ff @(posedge clk) begin
    if (reset) out_valid <= 1'b0;
    else       out_valid <= s2_valid;
    out.ch  <= {2'b00, s2_idx};
    out.val <= sat_val;
  end

endmodule

//--- hdl/tile_ctrl.sv
module tile_ctrl (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  pe_pkg::tile_cfg_t   cfg,
  output logic                busy,
  output logic                acc_clear,
  output logic                acc_en,
  output logic                row_issue,
  output logic [3:0]          row_idx,
  output logic                scale_on,
  output logic                tile_done
);

  pe_pkg::tile_cfg_t cfg_q;
  logic              start_ok;
  logic [31:0]       beat_last;

  logic              beat_flag;
  logic [31:0]       beat_cnt;
  logic              beat_begin;
  logic              beat_end;  // last beat of the tile

  logic              drain_flag;
  logic [5:0]        drain_cnt;
  logic              drain_begin;
  logic              drain_end;

  logic [15:0]       pof_m1;
  logic [5:0]        row_lim;   // first drain count past the last row
  logic [1:0]        end_d;     // end pulse through the pipeline

  assign start_ok = start && !busy;

  always_ff @(posedge clk) begin
    if (start_ok) cfg_q <= cfg;
  end

  // the start cycle already takes a beat, so compare against the new cfg
  assign beat_last = start_ok ? cfg.nif_k_k : cfg_q.nif_k_k;

  ////////////////////
  // beat counter
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      beat_flag <= 1'b0;
    end else if (start_ok && !beat_end) begin
      beat_flag <= 1'b1;
    end else if (beat_end) begin
      beat_flag <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      beat_cnt <= '0;
    end else if (beat_begin) begin
      beat_cnt <= beat_end ? '0 : beat_cnt + 32'd1;
    end
  end

  assign beat_begin = start_ok || beat_flag;
  assign beat_end   = beat_begin && (beat_cnt == beat_last);

  assign acc_clear = start_ok;
  assign acc_en    = beat_begin;

  ////////////////////
  // drain counter
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      drain_flag <= 1'b0;
    end else if (beat_end) begin
      drain_flag <= 1'b1;
    end else if (drain_end) begin
      drain_flag <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      drain_cnt <= '0;
    end else if (drain_begin) begin
      drain_cnt <= drain_end ? '0 : drain_cnt + 6'd1;
    end
  end

  assign drain_begin = drain_flag || beat_end;
  assign drain_end   = drain_begin && (drain_cnt == 6'(pe_pkg::DRAIN_LAST));

  // rows per core, ((pof - 1) mod 16) + 1
  assign pof_m1  = cfg_q.pof - 16'd1;
  assign row_lim = 6'(pe_pkg::DRAIN_FIRST) + {2'b00, pof_m1[3:0]} + 6'd1;

  assign row_issue = drain_flag && (drain_cnt >= 6'(pe_pkg::DRAIN_FIRST)) &&
                     (drain_cnt < row_lim);
  assign row_idx   = drain_cnt[3:0];  // drain_cnt - 16 inside the window
  assign scale_on  = (cfg_q.mode == 4'd1);

  ////////////////////
  // end of tile
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      end_d     <= '0;
      tile_done <= 1'b0;
      busy      <= 1'b0;
    end else begin
      end_d     <= {end_d[0], drain_end};
      tile_done <= end_d[pe_pkg::PIPE_DEPTH-2];
      if (start_ok) busy <= 1'b1;
      else if (end_d[pe_pkg::PIPE_DEPTH-2]) busy <= 1'b0;  // falls with tile_done
    end
  end

endmodule

//--- tb.f
hdl/pe_pkg.sv
hdl/tile_ctrl.sv
hdl/mac_array.sv
hdl/post_pipe.sv
hdl/param_ram.sv
hdl/param_arbiter.sv
hdl/axil_param_port.sv
hdl/conv_post_top.sv
testbench/tb_clock.sv
testbench/conv_post_assertions.sv
testbench/conv_post_tb.sv

//--- testbench/conv_post_assertions.sv
module conv_post_assertions (
  input logic             clk,
  input logic             reset,
  input logic             prd_en,
  input logic [3:0]       prd_idx,
  input logic             host_ready,
  input pe_pkg::mem_req_t host_req,
  input pe_pkg::mem_req_t mem_req,
  input logic             rdata_valid
);

  int fail_cnt = 0;  // count of failed assertions

  ////////////////////
  // grant rules
  ////////////////////
  one_grant: assert property (@(posedge clk) disable iff (reset)
    $onehot0({prd_en, host_ready}))
    else begin
      fail_cnt++;
      $error("pipeline and host granted in the same cycle");
    end

  // memory sees the pipeline read, never a host request
  pipe_first: assert property (@(posedge clk) disable iff (reset)
    prd_en |-> (!mem_req.wr && (mem_req.idx == prd_idx)))
    else begin
      fail_cnt++;
      $error("host request reached the memory during a pipeline read");
    end

  ////////////////////
  // host read data flag
  ////////////////////
  flag_after_read: assert property (@(posedge clk) disable iff (reset)
    rdata_valid |-> $past(host_ready && !host_req.wr))
    else begin
      fail_cnt++;
      $error("rdata_valid without a host read one cycle before");
    end

endmodule

bind param_arbiter conv_post_assertions u_arb_checks (.*);

//--- testbench/conv_post_stim.txt
# W idx scale bias    host write of one parameter entry (hex)
# T mode nif_k_k pof rows (decimal), then B act w15..w0 (hex) for each beat
W 0 0100 00000000
W 1 0100 00000400
W 2 0080 00000100
W 3 0100 00004000
W 4 0300 00010000
W 5 0100 ffffff00
W 6 0040 00000000
W 7 0100 00000080
W 8 0200 fffff000
W 9 0100 00000000
W a 0010 00000800
W b 0100 00000000
W c 0001 00003000
W d 0100 ffff0000
W e 0100 00000200
W f 0fff 00000000
T 1 1 5 5
B 64102030405060701122334400fe01817f
B f6f1e2d3c4b5a69788796a5b4002fc0510
T 0 2 16 16
B 7f7f8140c020e010f008f804fc02fe01ff
B 80017f02fe03fd04fc05fb06fa07f908f8
B 33112233445566778899aabbccddeeff00
T 1 0 20 4
B 050102030405060708090a0b0c7f8019e7
T 2 1 40 8
B 2a55aa55aa55aa55aa7f7f7f7f81818181
B 7b00000000000000007e60400ff0c0a082

//--- testbench/conv_post_tb.sv
module conv_post_tb;

  logic              clk;
  logic              reset;
  logic              start;
  pe_pkg::tile_cfg_t cfg;
  pe_pkg::in_beat_t  beat;
  logic              out_valid;
  pe_pkg::out_beat_t out;
  logic              tile_done;
  logic              busy;
  logic [7:0]        awaddr;
  logic              awvalid;
  logic              awready;
  logic [31:0]       wdata;
  logic [3:0]        wstrb;
  logic              wvalid;
  logic              wready;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;
  logic [7:0]        araddr;
  logic              arvalid;
  logic              arready;
  logic [31:0]       rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;

  integer seed;
  int     n_checks;
  int     n_errors;
  int     wait_limit = 200;  // cycles per wait loop

  // stimulus from the file
  logic [3:0]   wr_idx [$];
  logic [15:0]  wr_scale [$];
  logic [31:0]  wr_bias [$];
  logic [3:0]   tile_mode [$];
  logic [31:0]  tile_nkk [$];
  logic [15:0]  tile_pof [$];
  int           tile_rows [$];
  int           tile_first [$];  // index of the first beat
  logic [135:0] beats [$];

  // parameter memory as the host wrote it
  logic [15:0] scale_m [16];
  logic [31:0] bias_m [16];

  tb_clock u_clock (.clk(clk));

  conv_post_top dut (.*);

  task automatic abort_run(input string why);
    $display("%s", why);
    n_errors++;
    $display("checks %0d, errors %0d", n_checks, n_errors);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_cond(input bit ok, input string what);
    n_checks++;
    if (!ok) begin
      n_errors++;
      $display("%s", what);
    end
  endtask

  ////////////////////
  // stimulus file
  ////////////////////
  task automatic load_stim();
    int              fd;
    int              code;
    logic [7:0]      tag;
    logic [8*120-1:0] rest;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     c;
    logic [31:0]     d;
    logic [135:0]    bw;
    fd = $fopen("testbench/conv_post_stim.txt", "r");
    if (fd == 0) abort_run("cannot open testbench/conv_post_stim.txt");
    code = $fscanf(fd, " %c", tag);
    while (code == 1) begin
      case (tag)
        "#": code = $fgets(rest, fd);  // column notes
        "W": begin
          code = $fscanf(fd, "%h %h %h", a, b, c);
          wr_idx.push_back(4'(a));
          wr_scale.push_back(16'(b));
          wr_bias.push_back(c);
        end
        "T": begin
          code = $fscanf(fd, "%d %d %d %d", a, b, c, d);
          tile_mode.push_back(4'(a));
          tile_nkk.push_back(b);
          tile_pof.push_back(16'(c));
          tile_rows.push_back(int'(d));
          tile_first.push_back(beats.size());
        end
        "B": begin
          code = $fscanf(fd, "%h", bw);
          beats.push_back(bw);
        end
        default: abort_run("unknown line tag in the stimulus file");
      endcase
      code = $fscanf(fd, " %c", tag);
    end
    $fclose(fd);
  endtask

  ////////////////////
  // AXI4-Lite host
  ////////////////////
  task automatic write_param(input logic [7:0] addr, input logic [31:0] data);
    int t;
    int gap;
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = 4'hf;
    wvalid  = 1'b1;
    t = 0;
    @(posedge clk);
    while (!(awready && wready)) begin
      t++;
      if (t > wait_limit) abort_run("write address and data were never accepted");
      @(posedge clk);
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    t = 0;
    while (!bvalid) begin
      t++;
      if (t > wait_limit) abort_run("write response never came");
      @(negedge clk);
    end
    gap = $unsigned($random(seed)) % 4;  // bready held low
    repeat (gap) @(negedge clk);
    bready = 1'b1;
    check_value("bresp", bresp, pe_pkg::RESP_OKAY);
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic read_param(input logic [7:0] addr, output logic [31:0] data);
    int t;
    int gap;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    t = 0;
    @(posedge clk);
    while (!arready) begin
      t++;
      if (t > wait_limit) abort_run("read address was never accepted");
      @(posedge clk);
    end
    @(negedge clk);
    arvalid = 1'b0;
    t = 0;
    while (!rvalid) begin
      t++;
      if (t > wait_limit) abort_run("read data never came");
      @(negedge clk);
    end
    gap = $unsigned($random(seed)) % 4;
    repeat (gap) @(negedge clk);
    rready = 1'b1;
    data   = rdata;  // held while rvalid waits
    check_value("rresp", rresp, pe_pkg::RESP_OKAY);
    @(negedge clk);
    rready = 1'b0;
  endtask

  ////////////////////
  // reference model
  ////////////////////
  function automatic logic [7:0] expected_row(input int t, input int r);
    longint           acc;
    longint           v;
    pe_pkg::in_beat_t b;
    acc = 0;
    for (int i = 0; i <= tile_nkk[t]; i++) begin
      b = beats[tile_first[t] + i];
      acc += longint'(b.act) * longint'(b.wts.w[r]);
    end
    if (tile_mode[t] == 4'd1) v = acc * longint'(scale_m[r]) + longint'($signed(bias_m[r]));
    else v = acc + longint'($signed(bias_m[r]));  // no scale
    v = v >>> 8;
    if (v < 0) return 8'd0;  // relu
    if (v > 127) return 8'd127;
    return 8'(v);
  endfunction

  task automatic run_tile(input int t);
    int          n;
    int          k;
    bit          done_seen;
    logic [3:0]  ridx;
    logic [31:0] rd;
    n = 0;
    @(negedge clk);
    while (busy) begin
      n++;
      if (n > wait_limit) abort_run("busy never fell before a new tile");
      @(negedge clk);
    end
    start       = 1'b1;
    cfg.mode    = tile_mode[t];
    cfg.nif_k_k = tile_nkk[t];
    cfg.pof     = tile_pof[t];
    beat        = beats[tile_first[t]];  // first beat in the start cycle
    for (int i = 1; i <= tile_nkk[t]; i++) begin
      @(negedge clk);
      start = 1'b0;
      beat  = beats[tile_first[t] + i];
    end
    @(negedge clk);
    start = 1'b0;
    beat  = '0;
    ridx  = 4'(t * 5 + 2);
    fork
      begin
        k = 0;
        n = 0;  // cycles since the one after the last beat
        done_seen = 1'b0;
        while (!done_seen) begin
          if (out_valid) begin
            check_cond(k < tile_rows[t], "output beat past the folded row count");
            check_value("out.ch", out.ch, k);
            check_value("out.val", out.val, expected_row(t, k));
            // row k issued at drain count 16 + k, out 3 cycles later
            check_value("out_valid cycle", n,
                        pe_pkg::DRAIN_FIRST + pe_pkg::PIPE_DEPTH - 1 + k);
            k++;
          end
          if (tile_done) begin
            done_seen = 1'b1;
            check_value("tile_done cycle", n, pe_pkg::DRAIN_LAST + pe_pkg::PIPE_DEPTH - 1);
            check_value("busy", busy, 1'b0);
          end else begin
            n++;
            if (n > wait_limit) abort_run("tile_done never came");
            @(negedge clk);
          end
        end
        check_value("output beat count", k, tile_rows[t]);
      end
      begin
        repeat (3) @(negedge clk);
        check_cond(busy, "busy was low during the drain");
        start       = 1'b1;  // must be ignored
        cfg.nif_k_k = 32'd0;
        cfg.pof     = 16'd3;
        @(negedge clk);
        start = 1'b0;
        repeat (9) @(negedge clk);
        // lands on the pipeline reads
        read_param({1'b0, t[0], ridx, 2'b00}, rd);
        check_value("rdata", rd, t[0] ? bias_m[ridx] : {16'h0000, scale_m[ridx]});
      end
    join
    @(negedge clk);
    check_value("tile_done", tile_done, 1'b0);
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    logic [31:0] rd;
    seed     = 32'h3bf375af;
    n_checks = 0;
    n_errors = 0;
    reset    = 1'b1;
    start    = 1'b0;
    cfg      = '0;
    beat     = '0;
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    load_stim();

    repeat (5) @(negedge clk);
    reset = 1'b0;
    check_value("out_valid", out_valid, 1'b0);
    check_value("tile_done", tile_done, 1'b0);
    check_value("busy", busy, 1'b0);
    check_value("awready", awready, 1'b0);
    check_value("wready", wready, 1'b0);
    check_value("bvalid", bvalid, 1'b0);
    check_value("arready", arready, 1'b0);
    check_value("rvalid", rvalid, 1'b0);

    // parameters in, then read back
    for (int i = 0; i < wr_idx.size(); i++) begin
      write_param({2'b00, wr_idx[i], 2'b00}, {16'h0000, wr_scale[i]});
      write_param({2'b01, wr_idx[i], 2'b00}, wr_bias[i]);
      scale_m[wr_idx[i]] = wr_scale[i];
      bias_m[wr_idx[i]]  = wr_bias[i];
    end
    for (int i = 0; i < wr_idx.size(); i++) begin
      read_param({2'b00, wr_idx[i], 2'b00}, rd);
      check_value("rdata", rd, {16'h0000, scale_m[wr_idx[i]]});
      read_param({2'b01, wr_idx[i], 2'b00}, rd);
      check_value("rdata", rd, bias_m[wr_idx[i]]);
    end

    for (int t = 0; t < tile_mode.size(); t++) begin
      run_tile(t);
    end

    n_errors += dut.u_param_arbiter.u_arb_checks.fail_cnt;
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- testbench/tb_clock.sv
module tb_clock (
  output logic clk
);

  initial clk = 1'b0;

  always #50 clk = ~clk;  // period of 100

endmodule
